// ==== src/onfi_pkg.sv ====
// ONFI bus constants
`default_nettype none

package onfi_pkg;

	// ------------------------------
	// Bus width
	// ------------------------------

	// x8 bus only
	localparam int DQ_W = 8;

	// ------------------------------
	// Command bytes
	// ------------------------------

	localparam logic [DQ_W-1:0] CMD_RESET       = 8'hff;
	localparam logic [DQ_W-1:0] CMD_READ_STATUS = 8'h70;
	localparam logic [DQ_W-1:0] CMD_READ_ID     = 8'h90;

	// ------------------------------
	// Timing, in clock cycles
	// ------------------------------

	// WE# low and high time
	localparam int T_WP  = 2;
	localparam int T_WH  = 2;
	// RE# low and high time
	localparam int T_RP  = 2;
	localparam int T_REH = 2;
	// Last WE# rise to R/B# valid
	localparam int T_WB  = 4;
	// Command to status read
	localparam int T_WHR = 6;

	// Width of phase and delay counters, large enough for T_WHR
	localparam int CNT_W = 3;

	// Bytes returned by READ ID
	localparam int ID_BYTES = 5;

endpackage

`default_nettype wire

// ==== src/nand_ctrl_pkg.sv ====
// Controller types
`default_nettype none

package nand_ctrl_pkg;

	// ------------------------------
	// Host opcodes
	// ------------------------------

	typedef enum logic [5:0] {
		OP_GET_STATUS       = 6'd0,
		OP_CHIP_ENABLE      = 6'd1,
		OP_CHIP_DISABLE     = 6'd2,
		OP_WRITE_PROTECT    = 6'd3,
		OP_WRITE_ENABLE     = 6'd4,
		OP_RESET_INDEX      = 6'd5,
		OP_GET_ID_BYTE      = 6'd6,
		OP_NAND_RESET       = 6'd7,
		OP_NAND_READ_STATUS = 6'd8,
		OP_NAND_READ_ID     = 6'd9,
		OP_BYPASS_CMD       = 6'd10,
		OP_BYPASS_ADDR      = 6'd11,
		OP_BYPASS_WR        = 6'd12,
		OP_BYPASS_RD        = 6'd13
	} opcode_e;

	// ------------------------------
	// Sequencer states
	// ------------------------------

	// One running state per opcode, plus wait and delay
	typedef enum logic [4:0] {
		ST_RESET, ST_IDLE,
		ST_GET_STATUS, ST_CHIP_ENABLE, ST_CHIP_DISABLE,
		ST_WRITE_PROTECT, ST_WRITE_ENABLE, ST_RESET_INDEX, ST_GET_ID_BYTE,
		ST_NAND_RESET, ST_NAND_READ_STATUS, ST_NAND_READ_ID,
		ST_BYPASS_CMD, ST_BYPASS_ADDR, ST_BYPASS_WR, ST_BYPASS_RD,
		ST_WAIT, ST_DELAY
	} seq_state_e;

	// Kind of write-type bus cycle
	typedef enum logic [1:0] {
		KIND_CMD,
		KIND_ADDR,
		KIND_DATA
	} cycle_kind_e;

	// ------------------------------
	// Bus structs
	// ------------------------------

	// Pin request of one cycle unit
	typedef struct packed {
		logic busy;
		logic cle;
		logic ale;
		logic nwe;
		logic nre;
		logic [onfi_pkg::DQ_W-1:0] dq;
	} cycle_req_t;

	// Registered NAND pins
	typedef struct packed {
		logic cle;
		logic ale;
		logic nwe;
		logic nre;
		logic [onfi_pkg::DQ_W-1:0] dq;
		logic dq_oe;
	} nand_pins_t;

	// Controller status byte
	typedef struct packed {
		logic [2:0] rsvd_hi;
		logic idx_oor;   // bit 4, index out of range
		logic wp;        // bit 3, write protected
		logic ce;        // bit 2, chip enabled
		logic [1:0] rsvd_lo;
	} status_t;

	// Controller starts write protected, 08h
	localparam status_t STATUS_INIT = '{3'b000, 1'b0, 1'b1, 1'b0, 2'b00};

	// Pins with no cycle in progress
	localparam nand_pins_t PINS_IDLE = '{1'b0, 1'b0, 1'b1, 1'b1, '0, 1'b0};

endpackage

`default_nettype wire

// ==== src/nand_latch_cycle.sv ====
// NAND write-type cycle unit
`default_nettype none

module nand_latch_cycle #(
	parameter nand_ctrl_pkg::cycle_kind_e kind = nand_ctrl_pkg::KIND_CMD
) (
	input  logic clk,
	input  logic nreset,
	input  logic start,
	input  logic [onfi_pkg::DQ_W-1:0] byte_in,
	output nand_ctrl_pkg::cycle_req_t req
);

	import onfi_pkg::*;
	import nand_ctrl_pkg::*;

	logic active;
	logic [CNT_W-1:0] phase;
	logic [DQ_W-1:0] data_q;

	// Phase runs 0 .. T_WP+T_WH-1 while active
	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase <= '0;
		end else if (start) begin
			active <= 1'b1;
			phase <= '0;
		end else if (active) begin
			if (phase == CNT_W'(T_WP + T_WH - 1)) begin
				active <= 1'b0;
			end
			phase <= phase + 1'b1;
		end
	end

	// Byte to place on DQ, held for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			data_q <= byte_in;
		end
	end

	// CLE or ALE by kind, WE# low for the first T_WP cycles
	always_comb begin
		req.busy = active;
		req.cle = active && (kind == KIND_CMD);
		req.ale = active && (kind == KIND_ADDR);
		req.nwe = !(active && (phase < CNT_W'(T_WP)));
		req.nre = 1'b1;
		req.dq = data_q;
	end

	// Sequencer only starts an idle unit
	start_when_idle: assert property (@(posedge clk) disable iff (!nreset)
		start |-> !active);

endmodule

`default_nettype wire

// ==== src/nand_read_cycle.sv ====
// NAND read cycle unit
`default_nettype none

module nand_read_cycle (
	input  logic clk,
	input  logic nreset,
	input  logic start,
	input  logic [onfi_pkg::DQ_W-1:0] dq_in,
	output nand_ctrl_pkg::cycle_req_t req,
	output logic [onfi_pkg::DQ_W-1:0] byte_out
);

	import onfi_pkg::*;

	logic active;
	logic [CNT_W-1:0] phase;

	// RE# low for T_RP cycles, then high for T_REH
	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase <= '0;
		end else if (start) begin
			active <= 1'b1;
			phase <= '0;
		end else if (active) begin
			if (phase == CNT_W'(T_RP + T_REH - 1)) begin
				active <= 1'b0;
			end
			phase <= phase + 1'b1;
		end
	end

	// Capture on the last low cycle
	// byte stays until the next read
	always_ff @(posedge clk) begin
		if (active && (phase == CNT_W'(T_RP - 1))) begin
			byte_out <= dq_in;
		end
	end

	// Read never drives DQ, CLE or ALE
	always_comb begin
		req.busy = active;
		req.cle = 1'b0;
		req.ale = 1'b0;
		req.nwe = 1'b1;
		req.nre = !(active && (phase < CNT_W'(T_RP)));
		req.dq = '0;
	end

endmodule

`default_nettype wire

// ==== src/nand_bus_arbiter.sv ====
// NAND pin bus arbiter
`default_nettype none

module nand_bus_arbiter (
	input  logic clk,
	input  logic nreset,
	input  nand_ctrl_pkg::cycle_req_t cmd_req,
	input  nand_ctrl_pkg::cycle_req_t addr_req,
	input  nand_ctrl_pkg::cycle_req_t wr_req,
	input  nand_ctrl_pkg::cycle_req_t rd_req,
	output nand_ctrl_pkg::nand_pins_t pins
);

	import nand_ctrl_pkg::*;

	cycle_req_t grant;
	logic write_grant;
	nand_pins_t pins_d;

	// ------------------------------
	// Fixed priority grant
	// ------------------------------

	// Command, address, write, then read
	always_comb begin
		write_grant = 1'b1;
		if (cmd_req.busy) begin
			grant = cmd_req;
		end else if (addr_req.busy) begin
			grant = addr_req;
		end else if (wr_req.busy) begin
			grant = wr_req;
		end else begin
			grant = rd_req;
			write_grant = 1'b0;
		end
	end

	// Idle levels when nothing is busy
	always_comb begin
		if (grant.busy) begin
			pins_d.cle = grant.cle;
			pins_d.ale = grant.ale;
			pins_d.nwe = grant.nwe;
			pins_d.nre = grant.nre;
			pins_d.dq = grant.dq;
			// Controller drives DQ only on write-type cycles
			pins_d.dq_oe = write_grant;
		end else begin
			pins_d = PINS_IDLE;
		end
	end

	// ------------------------------
	// Pin register
	// ------------------------------

	always_ff @(posedge clk) begin
		if (!nreset) begin
			pins <= PINS_IDLE;
		end else begin
			pins <= pins_d;
		end
	end

	// Units never overlap on the bus
	one_unit_busy: assert property (@(posedge clk) disable iff (!nreset)
		$onehot0({cmd_req.busy, addr_req.busy, wr_req.busy, rd_req.busy}));

endmodule

`default_nettype wire

// ==== src/nand_sequencer.sv ====
// NAND opcode sequencer
`default_nettype none

module nand_sequencer (
	input  logic clk,
	input  logic nreset,
	input  logic pause,
	input  logic activate,
	input  nand_ctrl_pkg::opcode_e cmd_in,
	input  logic [onfi_pkg::DQ_W-1:0] data_in,
	input  logic rnb,
	input  logic [3:0] units_busy,
	input  logic [onfi_pkg::DQ_W-1:0] rd_byte,
	output logic busy,
	output logic [onfi_pkg::DQ_W-1:0] data_out,
	output logic nce,
	output logic nwp,
	output logic cmd_start,
	output logic addr_start,
	output logic wr_start,
	output logic rd_start,
	output logic [onfi_pkg::DQ_W-1:0] tx_byte
);

	import onfi_pkg::*;
	import nand_ctrl_pkg::*;

	seq_state_e state;
	seq_state_e ret_state;
	logic [2:0] step;
	logic [CNT_W-1:0] dly_cnt;
	status_t status;
	logic [2:0] index;
	logic [DQ_W-1:0] id_store [ID_BYTES];

	// Accepted request, held until the FSM leaves idle
	logic pend;
	opcode_e op_q;
	logic [DQ_W-1:0] data_q;
	logic units_idle;

	// Units idle and none about to start
	assign units_idle = (units_busy == 4'b0000) &&
		!(cmd_start || addr_start || wr_start || rd_start);

	// Opcode decode, unknown opcodes go to reset
	function automatic seq_state_e op_to_state(input opcode_e op);
		case (op)
			OP_GET_STATUS:       op_to_state = ST_GET_STATUS;
			OP_CHIP_ENABLE:      op_to_state = ST_CHIP_ENABLE;
			OP_CHIP_DISABLE:     op_to_state = ST_CHIP_DISABLE;
			OP_WRITE_PROTECT:    op_to_state = ST_WRITE_PROTECT;
			OP_WRITE_ENABLE:     op_to_state = ST_WRITE_ENABLE;
			OP_RESET_INDEX:      op_to_state = ST_RESET_INDEX;
			OP_GET_ID_BYTE:      op_to_state = ST_GET_ID_BYTE;
			OP_NAND_RESET:       op_to_state = ST_NAND_RESET;
			OP_NAND_READ_STATUS: op_to_state = ST_NAND_READ_STATUS;
			OP_NAND_READ_ID:     op_to_state = ST_NAND_READ_ID;
			OP_BYPASS_CMD:       op_to_state = ST_BYPASS_CMD;
			OP_BYPASS_ADDR:      op_to_state = ST_BYPASS_ADDR;
			OP_BYPASS_WR:        op_to_state = ST_BYPASS_WR;
			OP_BYPASS_RD:        op_to_state = ST_BYPASS_RD;
			default:             op_to_state = ST_RESET;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state <= ST_IDLE;
			ret_state <= ST_IDLE;
			step <= '0;
			dly_cnt <= '0;
			status <= STATUS_INIT;
			index <= '0;
			nce <= 1'b1;
			nwp <= 1'b0;
			busy <= 1'b0;
			pend <= 1'b0;
			cmd_start <= 1'b0;
			addr_start <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;
		end else begin
			// Start strobes last one cycle
			cmd_start <= 1'b0;
			addr_start <= 1'b0;
			wr_start <= 1'b0;
			rd_start <= 1'b0;

			// Host request is taken even while paused
			if (activate && !busy) begin
				busy <= 1'b1;
				pend <= 1'b1;
				op_q <= cmd_in;
				data_q <= data_in;
			end

			if (!pause) begin
				case (state)
					ST_IDLE: begin
						if (pend) begin
							state <= op_to_state(op_q);
							pend <= 1'b0;
							step <= '0;
						end
					end
					// ------------------------------
					// Register operations
					// ------------------------------
					ST_RESET: begin
						status <= STATUS_INIT;
						index <= '0;
						nce <= 1'b1;
						nwp <= 1'b0;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_GET_STATUS: begin
						data_out <= status;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_CHIP_ENABLE: begin
						nce <= 1'b0;
						status.ce <= 1'b1;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_CHIP_DISABLE: begin
						nce <= 1'b1;
						status.ce <= 1'b0;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_WRITE_PROTECT: begin
						nwp <= 1'b0;
						status.wp <= 1'b1;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_WRITE_ENABLE: begin
						nwp <= 1'b1;
						status.wp <= 1'b0;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					ST_RESET_INDEX: begin
						index <= '0;
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					// Past the last ID byte, wrap and flag
					ST_GET_ID_BYTE: begin
						if (index < 3'(ID_BYTES)) begin
							data_out <= id_store[index];
							index <= index + 1'b1;
							status.idx_oor <= 1'b0;
						end else begin
							data_out <= '0;
							index <= '0;
							status.idx_oor <= 1'b1;
						end
						state <= ST_IDLE;
						busy <= 1'b0;
					end
					// ------------------------------
					// NAND operations
					// ------------------------------
					// FFh, then hold for T_WB and R/B# high
					ST_NAND_RESET: begin
						ret_state <= ST_NAND_RESET;
						step <= step + 1'b1;
						case (step)
							3'd0: begin
								cmd_start <= 1'b1;
								tx_byte <= CMD_RESET;
								dly_cnt <= '0;
								state <= ST_WAIT;
							end
							3'd1: begin
								dly_cnt <= CNT_W'(T_WB);
								state <= ST_WAIT;
							end
							default: begin
								state <= ST_IDLE;
								busy <= 1'b0;
							end
						endcase
					end
					// 70h, tWHR, one read into data_out
					ST_NAND_READ_STATUS: begin
						ret_state <= ST_NAND_READ_STATUS;
						step <= step + 1'b1;
						case (step)
							3'd0: begin
								cmd_start <= 1'b1;
								tx_byte <= CMD_READ_STATUS;
								dly_cnt <= '0;
								state <= ST_WAIT;
							end
							3'd1: begin
								dly_cnt <= CNT_W'(T_WHR);
								state <= ST_DELAY;
							end
							3'd2: begin
								rd_start <= 1'b1;
								dly_cnt <= '0;
								state <= ST_WAIT;
							end
							default: begin
								data_out <= rd_byte;
								state <= ST_IDLE;
								busy <= 1'b0;
							end
						endcase
					end
					// 90h, address 00h, then five reads
					// index counts the bytes and is left at 0
					ST_NAND_READ_ID: begin
						ret_state <= ST_NAND_READ_ID;
						step <= step + 1'b1;
						dly_cnt <= '0;
						case (step)
							3'd0: begin
								cmd_start <= 1'b1;
								tx_byte <= CMD_READ_ID;
								state <= ST_WAIT;
							end
							3'd1: begin
								addr_start <= 1'b1;
								tx_byte <= '0;
								index <= '0;
								state <= ST_WAIT;
							end
							3'd2: begin
								dly_cnt <= CNT_W'(T_WB);
								state <= ST_DELAY;
							end
							3'd3: begin
								rd_start <= 1'b1;
								state <= ST_WAIT;
							end
							default: begin
								id_store[index] <= rd_byte;
								if (index == 3'(ID_BYTES - 1)) begin
									index <= '0;
									state <= ST_IDLE;
									busy <= 1'b0;
								end else begin
									index <= index + 1'b1;
									step <= 3'd3;
								end
							end
						endcase
					end
					// ------------------------------
					// Bypass operations
					// ------------------------------
					ST_BYPASS_CMD, ST_BYPASS_ADDR, ST_BYPASS_WR: begin
						if (step == '0) begin
							cmd_start <= (state == ST_BYPASS_CMD);
							addr_start <= (state == ST_BYPASS_ADDR);
							wr_start <= (state == ST_BYPASS_WR);
							tx_byte <= data_q;
							ret_state <= state;
							dly_cnt <= '0;
							step <= step + 1'b1;
							state <= ST_WAIT;
						end else begin
							state <= ST_IDLE;
							busy <= 1'b0;
						end
					end
					ST_BYPASS_RD: begin
						if (step == '0) begin
							rd_start <= 1'b1;
							ret_state <= ST_BYPASS_RD;
							dly_cnt <= '0;
							step <= step + 1'b1;
							state <= ST_WAIT;
						end else begin
							data_out <= rd_byte;
							state <= ST_IDLE;
							busy <= 1'b0;
						end
					end
					// ------------------------------
					// Wait and delay
					// ------------------------------
					// Delay first, then units idle and R/B# high
					ST_WAIT: begin
						if (dly_cnt != '0) begin
							dly_cnt <= dly_cnt - 1'b1;
						end else if (units_idle && rnb) begin
							state <= ret_state;
						end
					end
					ST_DELAY: begin
						if (dly_cnt != '0) begin
							dly_cnt <= dly_cnt - 1'b1;
						end else begin
							state <= ret_state;
						end
					end
					default: begin
						state <= ST_RESET;
					end
				endcase
			end
		end
	end

	// Host sees busy for every cycle the FSM is away from idle
	busy_out_of_idle: assert property (@(posedge clk) disable iff (!nreset)
		(state != ST_IDLE) |-> busy);

endmodule

`default_nettype wire

// ==== src/nand_master.sv ====
// ONFI NAND master top level
`default_nettype none

module nand_master (
	input  logic clk,
	input  logic nreset,
	input  logic pause,
	input  logic activate,
	input  nand_ctrl_pkg::opcode_e cmd_in,
	input  logic [onfi_pkg::DQ_W-1:0] data_in,
	input  logic rnb,
	input  logic [onfi_pkg::DQ_W-1:0] dq_in,
	output logic busy,
	output logic [onfi_pkg::DQ_W-1:0] data_out,
	output logic nce,
	output logic nwp,
	output nand_ctrl_pkg::nand_pins_t pins
);

	import onfi_pkg::*;
	import nand_ctrl_pkg::*;

	// Sequencer to cycle units
	logic cmd_start;
	logic addr_start;
	logic wr_start;
	logic rd_start;
	logic [DQ_W-1:0] tx_byte;
	logic [DQ_W-1:0] rd_byte;

	// Cycle units to arbiter
	cycle_req_t cmd_req;
	cycle_req_t addr_req;
	cycle_req_t wr_req;
	cycle_req_t rd_req;

	// ------------------------------
	// Opcode sequencer
	// ------------------------------
	nand_sequencer u_seq (
		.clk        (clk),
		.nreset     (nreset),
		.pause      (pause),
		.activate   (activate),
		.cmd_in     (cmd_in),
		.data_in    (data_in),
		.rnb        (rnb),
		.units_busy ({rd_req.busy, wr_req.busy, addr_req.busy, cmd_req.busy}),
		.rd_byte    (rd_byte),
		.busy       (busy),
		.data_out   (data_out),
		.nce        (nce),
		.nwp        (nwp),
		.cmd_start  (cmd_start),
		.addr_start (addr_start),
		.wr_start   (wr_start),
		.rd_start   (rd_start),
		.tx_byte    (tx_byte)
	);

	// ------------------------------
	// Cycle units
	// ------------------------------
	// Command latch, CLE high
	nand_latch_cycle #(.kind(KIND_CMD)) u_cmd (
		.clk     (clk),
		.nreset  (nreset),
		.start   (cmd_start),
		.byte_in (tx_byte),
		.req     (cmd_req)
	);

	// Address latch, ALE high
	nand_latch_cycle #(.kind(KIND_ADDR)) u_addr (
		.clk     (clk),
		.nreset  (nreset),
		.start   (addr_start),
		.byte_in (tx_byte),
		.req     (addr_req)
	);

	// Plain data write
	nand_latch_cycle #(.kind(KIND_DATA)) u_wr (
		.clk     (clk),
		.nreset  (nreset),
		.start   (wr_start),
		.byte_in (tx_byte),
		.req     (wr_req)
	);

	nand_read_cycle u_rd (
		.clk      (clk),
		.nreset   (nreset),
		.start    (rd_start),
		.dq_in    (dq_in),
		.req      (rd_req),
		.byte_out (rd_byte)
	);

	// Shared pin bus
	nand_bus_arbiter u_arb (
		.clk      (clk),
		.nreset   (nreset),
		.cmd_req  (cmd_req),
		.addr_req (addr_req),
		.wr_req   (wr_req),
		.rd_req   (rd_req),
		.pins     (pins)
	);

endmodule

`default_nettype wire

// ==== bench/nand_chip_model.sv ====
// Behavioral NAND chip
`default_nettype none

module nand_chip_model (
	input  logic clk,
	input  logic nreset,
	input  nand_ctrl_pkg::nand_pins_t pins,
	output logic rnb,
	output logic [7:0] dq_in,
	output logic [7:0] last_byte,
	output logic [1:0] last_kind
);

	timeunit 1ns;
	timeprecision 100ps;

	// Kind of the last latched byte
	localparam logic [1:0] LAST_CMD  = 2'd1;
	localparam logic [1:0] LAST_ADDR = 2'd2;
	localparam logic [1:0] LAST_DATA = 2'd3;

	// What a read returns
	localparam logic [1:0] MODE_BARE   = 2'd0;
	localparam logic [1:0] MODE_ID     = 2'd1;
	localparam logic [1:0] MODE_STATUS = 2'd2;

	// 0-4 ID, 5 status, 6 busy length, 7-9 bypass bytes, 10 bare read
	logic [7:0] golden [0:10];
	logic prev_nwe;
	logic prev_nre;
	logic [1:0] mode = MODE_BARE;
	logic [3:0] id_ptr = 4'd0;
	logic [7:0] rnb_cnt = 8'd0;

	initial begin
		$readmemh("bench/nand_golden.txt", golden);
	end

	// Ready once the busy count has run out
	assign rnb = (rnb_cnt == 8'd0);

	// Read data follows the last command
	always_comb begin
		case (mode)
			MODE_ID: dq_in = (id_ptr < 4'd5) ? golden[id_ptr] : 8'h00;
			MODE_STATUS: dq_in = golden[5];
			default: dq_in = golden[10];
		endcase
	end

	// ------------------------------
	// Cycle decode on WE# and RE# rise
	// ------------------------------
	always @(posedge clk) begin
		if (!nreset) begin
			prev_nwe <= 1'b1;
			prev_nre <= 1'b1;
			mode <= MODE_BARE;
			id_ptr <= 4'd0;
			rnb_cnt <= 8'd0;
			last_byte <= 8'h00;
			last_kind <= 2'd0;
		end else begin
			prev_nwe <= pins.nwe;
			prev_nre <= pins.nre;
			if (rnb_cnt != 8'd0) begin
				rnb_cnt <= rnb_cnt - 8'd1;
			end
			// CLE, ALE and DQ are still held on the WE# rise
			if (!prev_nwe && pins.nwe) begin
				// DQ floats unless the controller drives it
				last_byte <= pins.dq_oe ? pins.dq : 8'hxx;
				if (pins.cle) begin
					last_kind <= LAST_CMD;
					case (pins.dq)
						8'h90: mode <= MODE_ID;
						8'h70: mode <= MODE_STATUS;
						8'hff: begin
							// Reset keeps R/B# low for the golden time
							mode <= MODE_BARE;
							rnb_cnt <= golden[6];
						end
						default: mode <= MODE_BARE;
					endcase
				end else if (pins.ale) begin
					last_kind <= LAST_ADDR;
					id_ptr <= 4'd0;
				end else begin
					last_kind <= LAST_DATA;
				end
			end
			// Next ID byte after each RE# pulse
			if (!prev_nre && pins.nre && (mode == MODE_ID)) begin
				id_ptr <= id_ptr + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_nand_master.sv ====
// NAND master testbench
`default_nettype none

module tb_nand_master;

	timeunit 1ns;
	timeprecision 100ps;

	import nand_ctrl_pkg::*;

	// Kind codes reported by the chip model
	localparam logic [1:0] LAST_CMD  = 2'd1;
	localparam logic [1:0] LAST_ADDR = 2'd2;
	localparam logic [1:0] LAST_DATA = 2'd3;

	// Longest single operation, in cycles
	localparam int OP_LIMIT = 200;

	// ------------------------------
	// Run length, cycles per test
	// ------------------------------
	localparam int BUDGET_RESET = 20;
	localparam int BUDGET_T1 = 40;
	localparam int BUDGET_T2 = 200;
	localparam int BUDGET_T3 = 300;
	localparam int BUDGET_T4 = 200;
	localparam int BUDGET_T5 = 150;
	localparam int BUDGET_T6 = 80;
	localparam int WATCHDOG_CYCLES = BUDGET_RESET + BUDGET_T1 + BUDGET_T2 +
		BUDGET_T3 + BUDGET_T4 + BUDGET_T5 + BUDGET_T6;

	logic clk;
	logic nreset;
	logic pause;
	logic activate;
	opcode_e cmd_in;
	logic [7:0] data_in;
	logic rnb;
	logic [7:0] dq_in;
	logic busy;
	logic [7:0] data_out;
	logic nce;
	logic nwp;
	nand_pins_t pins;
	logic [7:0] last_byte;
	logic [1:0] last_kind;

	// Same layout as in the chip model
	logic [7:0] golden [0:10];

	// Running model of the status register
	logic exp_ce;
	logic exp_wp;
	logic exp_oor;

	opcode_e reg_ops [4];
	logic [31:0] lcg_state = 32'h99c7_d585;
	int errors = 0;
	int checks = 0;
	int err_before;
	int busy_cycles;

	nand_master dut0 (
		.clk      (clk),
		.nreset   (nreset),
		.pause    (pause),
		.activate (activate),
		.cmd_in   (cmd_in),
		.data_in  (data_in),
		.rnb      (rnb),
		.dq_in    (dq_in),
		.busy     (busy),
		.data_out (data_out),
		.nce      (nce),
		.nwp      (nwp),
		.pins     (pins)
	);

	nand_chip_model chip0 (
		.clk       (clk),
		.nreset    (nreset),
		.pins      (pins),
		.rnb       (rnb),
		.dq_in     (dq_in),
		.last_byte (last_byte),
		.last_kind (last_kind)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired before the tests ended");
		$display("test failed");
		$finish;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Status byte as the opcode table defines it
	function automatic logic [7:0] expected_status();
		return {3'b000, exp_oor, exp_wp, exp_ce, 2'b00};
	endfunction

	task automatic check_hex(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got %02h, expected %02h", name, got, exp);
			errors++;
		end
	endtask

	// Activate is sampled on the second edge
	task automatic start_op(input opcode_e op, input logic [7:0] din);
		@(posedge clk);
		activate <= 1'b1;
		cmd_in <= op;
		data_in <= din;
		@(posedge clk);
		activate <= 1'b0;
	endtask

	// Counts busy cycles up to the fall of busy
	task automatic wait_idle(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (busy && (cycles < OP_LIMIT)) begin
			@(negedge clk);
			cycles++;
		end
		if (busy) begin
			$display("operation still busy after %0d cycles", OP_LIMIT);
			errors++;
		end
	endtask

	task automatic run_op(input opcode_e op, input logic [7:0] din, output int cycles);
		start_op(op, din);
		wait_idle(cycles);
	endtask

	task automatic check_status();
		run_op(OP_GET_STATUS, 8'h00, busy_cycles);
		check_hex("data_out", data_out, expected_status());
	endtask

	// Fisher-Yates on the register opcodes
	task automatic shuffle_ops();
		opcode_e tmp;
		int j;
		for (int i = 3; i > 0; i--) begin
			j = int'(lcg_next() >> 8) % (i + 1);
			tmp = reg_ops[i];
			reg_ops[i] = reg_ops[j];
			reg_ops[j] = tmp;
		end
	endtask

	function automatic void apply_reg_op(input opcode_e op);
		case (op)
			OP_CHIP_ENABLE: exp_ce = 1'b1;
			OP_CHIP_DISABLE: exp_ce = 1'b0;
			OP_WRITE_PROTECT: exp_wp = 1'b1;
			OP_WRITE_ENABLE: exp_wp = 1'b0;
			default: ;
		endcase
	endfunction

	task automatic report_test(input int num, input string name, input int err_start);
		$display("test %0d, %s: %0d errors", num, name, errors - err_start);
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		nreset = 1'b0;
		pause = 1'b0;
		activate = 1'b0;
		cmd_in = OP_GET_STATUS;
		data_in = 8'h00;
		reg_ops[0] = OP_CHIP_ENABLE;
		reg_ops[1] = OP_CHIP_DISABLE;
		reg_ops[2] = OP_WRITE_PROTECT;
		reg_ops[3] = OP_WRITE_ENABLE;
		$readmemh("bench/nand_golden.txt", golden);
		// Controller comes up write protected
		exp_ce = 1'b0;
		exp_wp = 1'b1;
		exp_oor = 1'b0;
		repeat (5) @(posedge clk);
		nreset <= 1'b1;

		// Reset values and idle pins
		err_before = errors;
		@(negedge clk);
		check_hex("busy", {7'b0, busy}, 8'h00);
		check_hex("nce", {7'b0, nce}, 8'h01);
		check_hex("nwp", {7'b0, nwp}, 8'h00);
		check_hex("pins.cle", {7'b0, pins.cle}, 8'h00);
		check_hex("pins.ale", {7'b0, pins.ale}, 8'h00);
		check_hex("pins.nwe", {7'b0, pins.nwe}, 8'h01);
		check_hex("pins.nre", {7'b0, pins.nre}, 8'h01);
		check_hex("pins.dq_oe", {7'b0, pins.dq_oe}, 8'h00);
		check_status();
		report_test(1, "reset values", err_before);

		// Register opcodes, two shuffled rounds
		err_before = errors;
		for (int round = 0; round < 2; round++) begin
			shuffle_ops();
			for (int k = 0; k < 4; k++) begin
				run_op(reg_ops[k], 8'h00, busy_cycles);
				apply_reg_op(reg_ops[k]);
				check_hex("nce", {7'b0, nce}, {7'b0, !exp_ce});
				check_hex("nwp", {7'b0, nwp}, {7'b0, !exp_wp});
				check_status();
			end
		end
		report_test(2, "register opcodes", err_before);

		// READ ID, then the index readout
		err_before = errors;
		run_op(OP_NAND_READ_ID, 8'h00, busy_cycles);
		for (int k = 0; k < 5; k++) begin
			run_op(OP_GET_ID_BYTE, 8'h00, busy_cycles);
			check_hex("data_out", data_out, golden[k]);
			check_status();
		end
		// Past the end, index wraps and bit 4 is set
		run_op(OP_GET_ID_BYTE, 8'h00, busy_cycles);
		check_hex("data_out", data_out, 8'h00);
		exp_oor = 1'b1;
		check_status();
		// Wrapped index reads the first byte again
		// A good read clears bit 4
		run_op(OP_GET_ID_BYTE, 8'h00, busy_cycles);
		check_hex("data_out", data_out, golden[0]);
		exp_oor = 1'b0;
		check_status();
		// Index now points past the first byte
		run_op(OP_RESET_INDEX, 8'h00, busy_cycles);
		run_op(OP_GET_ID_BYTE, 8'h00, busy_cycles);
		check_hex("data_out", data_out, golden[0]);
		check_status();
		report_test(3, "read ID", err_before);

		// Chip status and chip reset
		err_before = errors;
		run_op(OP_NAND_READ_STATUS, 8'h00, busy_cycles);
		check_hex("data_out", data_out, golden[5]);
		run_op(OP_NAND_RESET, 8'h00, busy_cycles);
		checks++;
		if (busy_cycles < int'(golden[6])) begin
			$display("NAND reset was busy for %0d cycles, less than the %0d of R/B# low",
				busy_cycles, golden[6]);
			errors++;
		end
		check_hex("last_byte", last_byte, 8'hff);
		check_hex("last_kind", {6'b0, last_kind}, {6'b0, LAST_CMD});
		report_test(4, "status and reset", err_before);

		// Bypass operations
		err_before = errors;
		run_op(OP_BYPASS_CMD, golden[7], busy_cycles);
		check_hex("last_byte", last_byte, golden[7]);
		check_hex("last_kind", {6'b0, last_kind}, {6'b0, LAST_CMD});
		run_op(OP_BYPASS_ADDR, golden[8], busy_cycles);
		check_hex("last_byte", last_byte, golden[8]);
		check_hex("last_kind", {6'b0, last_kind}, {6'b0, LAST_ADDR});
		run_op(OP_BYPASS_WR, golden[9], busy_cycles);
		check_hex("last_byte", last_byte, golden[9]);
		check_hex("last_kind", {6'b0, last_kind}, {6'b0, LAST_DATA});
		run_op(OP_BYPASS_RD, 8'h00, busy_cycles);
		check_hex("data_out", data_out, golden[10]);
		report_test(5, "bypass", err_before);

		// Pause holds the sequencer, busy stays up
		err_before = errors;
		@(posedge clk);
		pause <= 1'b1;
		start_op(OP_GET_STATUS, 8'h00);
		repeat (10) begin
			@(negedge clk);
			check_hex("busy", {7'b0, busy}, 8'h01);
			check_hex("data_out", data_out, golden[10]);
		end
		@(posedge clk);
		pause <= 1'b0;
		wait_idle(busy_cycles);
		check_hex("data_out", data_out, expected_status());
		report_test(6, "pause", err_before);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/nand_golden.txt ====
// NAND golden data, one hex byte per line
// 0-4 ID bytes, 5 chip status, 6 R/B# low cycles after FFh
// 7 bypass command, 8 bypass address, 9 bypass data, 10 bare read byte
2c
dc
90
95
56
// Chip status, ready and not protected
e0
// R/B# low time, 20 cycles
14
// Bypass command, not a decoded command
85
3a
a5
// Returned by a read with no ID or status command before it
5c

// ==== vlog.f ====
src/onfi_pkg.sv
src/nand_ctrl_pkg.sv
src/nand_latch_cycle.sv
src/nand_read_cycle.sv
src/nand_bus_arbiter.sv
src/nand_sequencer.sv
src/nand_master.sv
bench/nand_chip_model.sv
bench/tb_nand_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_nand_master -f vlog.f \
	--Mdir obj_dir -o sim_nand_master

./obj_dir/sim_nand_master | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
